// File: project.f
src/pet_pkg.sv
src/spi_target.sv
src/spi_cmd.sv
src/bus_timing.sv
src/ctrl_regs.sv
src/bus_ctrl.sv
src/pet_main.sv
test/ram_model.sv
test/tb_pet_main.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_pet_main \
    && ./obj_dir/Vtb_pet_main | tee /dev/stderr | grep -q "Result: PASSED" \
    || { echo "Simulation did not pass"; exit 1; }

// File: test/tb_pet_main.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pet_main;

    // Fixed entries then sixteen random writes and their read-backs
    localparam int N_FIXED   = 7;
    localparam int N_RANDOM  = 16;
    localparam int N_ENTRIES = N_FIXED + 2 * N_RANDOM;

    // Four bytes of sixteen SCK half periods per entry plus bus frames
    localparam int TIMEOUT_CYCLES = N_ENTRIES * 4 * 16 * 8 +
                                    N_ENTRIES * 4 * pet_pkg::FRAME_LEN;

    // Bit 16 set selects the control register
    localparam logic [16:0] REG_ADDR = 17'h10000;

    logic        clk16;
    logic        reset;
    logic        spi_sck;
    logic        spi_cs_n;
    logic        spi_mosi;
    logic        spi_miso;
    logic        spi_ready;
    logic [7:0]  bus_rd_data;
    logic [16:0] bus_addr;
    logic [7:0]  bus_wr_data;
    logic        bus_data_oe;
    logic        bus_rw_n;
    logic        cpu_clk;
    logic        cpu_res;
    logic        cpu_ready;
    logic        cpu_be;
    logic        ram_ce;
    logic        ram_oe;
    logic        ram_we;
    logic [11:10] ram_addr_hi;

    // Stimulus table with expected reply and control byte after each entry
    pet_pkg::spi_op_e tbl_op   [0:N_ENTRIES-1];
    logic [16:0]      tbl_addr [0:N_ENTRIES-1];
    logic [7:0]       tbl_data [0:N_ENTRIES-1];
    logic [7:0]       tbl_exp  [0:N_ENTRIES-1];
    logic [7:0]       tbl_ctrl [0:N_ENTRIES-1];

    // Reference state used while the table is built
    logic [7:0]       shadow_mem [0:65535];
    logic [7:0]       shadow_ctrl;
    logic [15:0]      rand_addr [0:N_RANDOM-1];

    // Entry on the bus right now
    logic [16:0]      cur_addr;
    logic [7:0]       cur_data;
    logic             cur_write;

    int               n_built;
    int               exp_we_pulses;
    int               we_pulses;
    int               cycle_cnt;
    logic             we_prev;
    logic [7:0]       reply;

    pet_main i_pet_main (
        .clk16_i       (clk16),
        .reset_i       (reset),
        .spi1_sck_i    (spi_sck),
        .spi1_cs_ni    (spi_cs_n),
        .spi1_rx_i     (spi_mosi),
        .spi1_tx_o     (spi_miso),
        .spi_ready_o   (spi_ready),
        .bus_data_i    (bus_rd_data),
        .bus_addr_o    (bus_addr),
        .bus_data_o    (bus_wr_data),
        .bus_data_oe_o (bus_data_oe),
        .bus_rw_n_o    (bus_rw_n),
        .cpu_clk_o     (cpu_clk),
        .cpu_res_o     (cpu_res),
        .cpu_ready_o   (cpu_ready),
        .cpu_be_o      (cpu_be),
        .ram_ce_o      (ram_ce),
        .ram_oe_o      (ram_oe),
        .ram_we_o      (ram_we),
        .ram_addr_o    (ram_addr_hi)
    );

    ram_model i_ram_model (
        .clk_i  (clk16),
        .addr_i (bus_addr),
        .data_i (bus_wr_data),
        .ce_i   (ram_ce),
        .oe_i   (ram_oe),
        .we_i   (ram_we),
        .data_o (bus_rd_data)
    );

    // System clock with a 10 ns period
    always #5 clk16 = ~clk16;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s = %02h, expected %02h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s = %b, expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk16);
    endtask

    // Appends one entry and updates the reference state
    task automatic add_entry(input pet_pkg::spi_op_e op, input logic [16:0] addr,
                             input logic [7:0] data);
        tbl_op[n_built]   = op;
        tbl_addr[n_built] = addr;
        tbl_data[n_built] = data;
        tbl_exp[n_built]  = 8'h00;
        if (op == pet_pkg::OP_WRITE) begin
            if (addr[16]) begin
                shadow_ctrl = data;
            end else begin
                shadow_mem[addr[15:0]] = data;
                exp_we_pulses++;
            end
        end else begin
            tbl_exp[n_built] = addr[16] ? shadow_ctrl : shadow_mem[addr[15:0]];
        end
        tbl_ctrl[n_built] = shadow_ctrl;
        n_built++;
    endtask

    // Mode 0 byte with MOSI set while SCK is low and MISO sampled just before the rise
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            spi_mosi = tx[i];
            spi_sck  = 1'b0;
            wait_cycles(4);
            rx[i]    = spi_miso;
            spi_sck  = 1'b1;
            wait_cycles(4);
        end
        spi_sck = 1'b0;
        wait_cycles(4);
    endtask

    task automatic wait_ready();
        while (!spi_ready) begin
            @(negedge clk16);
        end
    endtask

    task automatic run_command(input pet_pkg::spi_op_e op, input logic [16:0] addr,
                               input logic [7:0] data, output logic [7:0] rx_data);
        logic [7:0] dummy;
        rx_data  = 8'h00;
        spi_cs_n = 1'b0;
        wait_cycles(4);
        spi_byte({op, 3'b000, addr[16]}, dummy);
        spi_byte(addr[15:8], dummy);
        spi_byte(addr[7:0], dummy);
        if (op == pet_pkg::OP_WRITE) begin
            spi_byte(data, dummy);
        end
        // Bus access runs in the FPGA slot of a later frame
        wait_ready();
        if (op == pet_pkg::OP_READ) begin
            spi_byte(8'h00, rx_data);
        end
        spi_cs_n = 1'b1;
        wait_cycles(8);
    endtask

    // 6502 must never own the bus during a RAM write strobe
    always @(negedge clk16) begin
        if (!reset) begin
            if (ram_we) begin
                check_bit("cpu_be_o", cpu_be, 1'b0);
                check_bit("bus_data_oe_o", bus_data_oe, 1'b1);
                check_bit("bus_rw_n_o", bus_rw_n, 1'b0);
                check_bit("ram_addr_o[11]", ram_addr_hi[11], cur_addr[11]);
                check_bit("ram_addr_o[10]", ram_addr_hi[10], cur_addr[10]);
                check_byte("bus_data_o", bus_wr_data, cur_data);
            end else begin
                // FPGA drives the data bus only for a RAM write
                check_bit("bus_data_oe_o", bus_data_oe, 1'b0);
            end
            if (!cur_write) begin
                check_bit("bus_rw_n_o", bus_rw_n, 1'b1);
            end
            if (ram_we && !we_prev) begin
                we_pulses++;
            end
            we_prev = ram_we;
        end
    end

    // Watchdog
    always @(negedge clk16) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: no progress after %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    initial begin
        logic [31:0] seed;
        clk16         = 1'b0;
        reset         = 1'b1;
        spi_sck       = 1'b0;
        spi_cs_n      = 1'b1;
        spi_mosi      = 1'b0;
        we_prev       = 1'b0;
        cur_addr      = 17'h00000;
        cur_data      = 8'h00;
        cur_write     = 1'b0;
        n_built       = 0;
        exp_we_pulses = 0;
        we_pulses     = 0;
        cycle_cnt     = 0;
        shadow_ctrl   = 8'h01;
        seed          = 32'h058b20a3;

        // Reset value, RAM round trip, register write, alias check
        add_entry(pet_pkg::OP_READ,  REG_ADDR,  8'h00);
        add_entry(pet_pkg::OP_WRITE, 17'h00123, 8'ha5);
        add_entry(pet_pkg::OP_READ,  17'h00123, 8'h00);
        add_entry(pet_pkg::OP_WRITE, 17'h00000, 8'h3c);
        add_entry(pet_pkg::OP_WRITE, REG_ADDR,  8'h02);
        add_entry(pet_pkg::OP_READ,  REG_ADDR,  8'h00);
        add_entry(pet_pkg::OP_READ,  17'h00000, 8'h00);

        // Random writes come first so repeated addresses end on the last value
        for (int r = 0; r < N_RANDOM; r++) begin
            seed         = lcg_next(seed);
            rand_addr[r] = seed[23:8];
            add_entry(pet_pkg::OP_WRITE, {1'b0, rand_addr[r]}, seed[31:24]);
        end
        for (int r = 0; r < N_RANDOM; r++) begin
            add_entry(pet_pkg::OP_READ, {1'b0, rand_addr[r]}, 8'h00);
        end

        wait_cycles(4);
        // State at the end of reset
        check_bit("spi_ready_o", spi_ready, 1'b1);
        check_bit("cpu_res_o", cpu_res, 1'b1);
        check_bit("cpu_ready_o", cpu_ready, 1'b0);
        check_bit("ram_we_o", ram_we, 1'b0);
        reset = 1'b0;

        // One frame with the CPU half from cycle 8
        for (int k = 0; k < pet_pkg::FRAME_LEN; k++) begin
            check_bit("cpu_be_o", cpu_be, k >= 8);
            check_bit("cpu_clk_o", cpu_clk, k >= 8);
            wait_cycles(1);
        end

        for (int n = 0; n < N_ENTRIES; n++) begin
            cur_addr  = tbl_addr[n];
            cur_data  = tbl_data[n];
            cur_write = (tbl_op[n] == pet_pkg::OP_WRITE);
            run_command(tbl_op[n], tbl_addr[n], tbl_data[n], reply);
            if (tbl_op[n] == pet_pkg::OP_READ) begin
                check_byte("spi1_tx_o reply", reply, tbl_exp[n]);
            end
            check_bit("cpu_res_o", cpu_res, tbl_ctrl[n][0]);
            check_bit("cpu_ready_o", cpu_ready, tbl_ctrl[n][1]);
        end

        // Register writes must not strobe the RAM
        if (we_pulses != exp_we_pulses) begin
            $display("RAM write strobe seen %0d times, expected %0d", we_pulses, exp_we_pulses);
            stop_on_failure();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: test/ram_model.sv
`timescale 1ns/1ns
`default_nettype none

module ram_model (
    input  logic        clk_i,
    input  logic [16:0] addr_i,
    input  logic [7:0]  data_i,
    input  logic        ce_i,
    input  logic        oe_i,
    input  logic        we_i,
    output logic [7:0]  data_o
);

    // 128K x 8 SRAM array
    logic [7:0]  mem [0:131071];
    logic [16:0] fill_addr;

    // Power-up contents depend on every address bit
    initial begin
        for (int a = 0; a < 131072; a++) begin
            fill_addr = 17'(a);
            mem[a]    = fill_addr[7:0] ^ fill_addr[15:8] ^ {fill_addr[16], 7'h2d};
        end
    end

    // Write while selected and strobed
    always @(posedge clk_i) begin
        if (ce_i && we_i) begin
            mem[addr_i] <= data_i;
        end
    end

    // Undriven bus reads as all ones
    assign data_o = (ce_i && oe_i) ? mem[addr_i] : 8'hff;

endmodule

`default_nettype wire

// File: src/pet_main.sv
`timescale 1ns/1ns
`default_nettype none

module pet_main (
    input  logic                           clk16_i,
    input  logic                           reset_i,

    // SPI from the host MCU
    input  logic                           spi1_sck_i,
    input  logic                           spi1_cs_ni,
    input  logic                           spi1_rx_i,
    output logic                           spi1_tx_o,
    output logic                           spi_ready_o,

    // System bus
    input  logic [7:0]                     bus_data_i,
    output logic [pet_pkg::BUS_ADDR_W-1:0] bus_addr_o,
    output logic [7:0]                     bus_data_o,
    output logic                           bus_data_oe_o,
    output logic                           bus_rw_n_o,

    // 6502
    output logic                           cpu_clk_o,
    output logic                           cpu_res_o,
    output logic                           cpu_ready_o,
    output logic                           cpu_be_o,

    // SRAM
    output logic                           ram_ce_o,
    output logic                           ram_oe_o,
    output logic                           ram_we_o,
    output logic [11:10]                   ram_addr_o
);

    // SPI byte stream
    logic [7:0]                     tx_byte;
    logic [7:0]                     rx_byte;
    logic                           rx_valid;
    logic                           cs_active;

    // Request handshake
    logic                           req_valid;
    logic [pet_pkg::BUS_ADDR_W-1:0] req_addr;
    logic [7:0]                     req_data;
    logic                           req_rw_n;
    logic                           req_done;
    logic [7:0]                     rd_data;

    // Frame timing
    logic                           slot_en;

    // Register bank
    logic                           reg_wr_en;
    logic [7:0]                     reg_rd_data;

    spi_target i_spi_target (
        .clk16_i     (clk16_i),
        .reset_i     (reset_i),
        .spi_sck_i   (spi1_sck_i),
        .spi_cs_ni   (spi1_cs_ni),
        .spi_rx_i    (spi1_rx_i),
        .spi_tx_o    (spi1_tx_o),
        .tx_byte_i   (tx_byte),
        .rx_byte_o   (rx_byte),
        .rx_valid_o  (rx_valid),
        .cs_active_o (cs_active)
    );

    spi_cmd i_spi_cmd (
        .clk16_i     (clk16_i),
        .reset_i     (reset_i),
        .rx_byte_i   (rx_byte),
        .rx_valid_i  (rx_valid),
        .cs_active_i (cs_active),
        .tx_byte_o   (tx_byte),
        .req_valid_o (req_valid),
        .req_addr_o  (req_addr),
        .req_data_o  (req_data),
        .req_rw_n_o  (req_rw_n),
        .req_done_i  (req_done),
        .rd_data_i   (rd_data),
        .spi_ready_o (spi_ready_o)
    );

    bus_timing i_bus_timing (
        .clk16_i     (clk16_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid),
        .slot_en_o   (slot_en),
        .done_o      (req_done),
        .cpu_clk_o   (cpu_clk_o),
        .cpu_be_o    (cpu_be_o)
    );

    ctrl_regs i_ctrl_regs (
        .clk16_i     (clk16_i),
        .reset_i     (reset_i),
        .wr_en_i     (reg_wr_en),
        .wr_data_i   (req_data),
        .rd_data_o   (reg_rd_data),
        .cpu_res_o   (cpu_res_o),
        .cpu_ready_o (cpu_ready_o)
    );

    bus_ctrl i_bus_ctrl (
        .clk16_i       (clk16_i),
        .reset_i       (reset_i),
        .req_addr_i    (req_addr),
        .req_data_i    (req_data),
        .req_rw_n_i    (req_rw_n),
        .slot_en_i     (slot_en),
        .done_i        (req_done),
        .bus_data_i    (bus_data_i),
        .reg_data_i    (reg_rd_data),
        .bus_addr_o    (bus_addr_o),
        .bus_data_o    (bus_data_o),
        .bus_data_oe_o (bus_data_oe_o),
        .bus_rw_n_o    (bus_rw_n_o),
        .ram_ce_o      (ram_ce_o),
        .ram_oe_o      (ram_oe_o),
        .ram_we_o      (ram_we_o),
        .reg_wr_en_o   (reg_wr_en),
        .rd_data_o     (rd_data)
    );

    // Separate SRAM pins for A11:A10
    assign ram_addr_o = bus_addr_o[11:10];

endmodule

`default_nettype wire

// File: src/bus_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module bus_ctrl (
    input  logic                           clk16_i,
    input  logic                           reset_i,
    input  logic [pet_pkg::BUS_ADDR_W-1:0] req_addr_i,
    input  logic [7:0]                     req_data_i,
    input  logic                           req_rw_n_i,
    input  logic                           slot_en_i,
    input  logic                           done_i,
    input  logic [7:0]                     bus_data_i,
    input  logic [7:0]                     reg_data_i,
    output logic [pet_pkg::BUS_ADDR_W-1:0] bus_addr_o,
    output logic [7:0]                     bus_data_o,
    output logic                           bus_data_oe_o,
    output logic                           bus_rw_n_o,
    output logic                           ram_ce_o,
    output logic                           ram_oe_o,
    output logic                           ram_we_o,
    output logic                           reg_wr_en_o,
    output logic [7:0]                     rd_data_o
);

    // Bit 16 set targets the control register bank
    logic       is_reg;
    logic [7:0] rd_data_q;

    assign is_reg = req_addr_i[pet_pkg::BUS_ADDR_W-1];

    assign bus_addr_o    = req_addr_i;
    assign bus_data_o    = req_data_i;

    // Drive data and RW only inside the owned slot
    assign bus_data_oe_o = slot_en_i && !req_rw_n_i && !is_reg;
    assign bus_rw_n_o    = !(slot_en_i && !req_rw_n_i);

    // RAM stays selected for the CPU and drops only for register accesses
    assign ram_ce_o      = !(slot_en_i && is_reg);
    assign ram_oe_o      = req_rw_n_i;
    assign ram_we_o      = slot_en_i && !req_rw_n_i && !is_reg;

    // Single write pulse at slot end
    assign reg_wr_en_o   = done_i && !req_rw_n_i && is_reg;

    // Read data sampled at the end of the slot
    always_ff @(posedge clk16_i) begin
        if (done_i && req_rw_n_i) begin
            rd_data_q <= is_reg ? reg_data_i : bus_data_i;
        end
    end

    assign rd_data_o = rd_data_q;

    // Address and data held by spi_cmd across the whole write strobe
    a_we_in_slot: assert property (
        @(posedge clk16_i) disable iff (reset_i)
        ram_we_o && $past(ram_we_o) |-> $stable(bus_addr_o) && $stable(bus_data_o)
    );

endmodule

`default_nettype wire

// File: src/ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

module ctrl_regs (
    input  logic       clk16_i,
    input  logic       reset_i,
    input  logic       wr_en_i,
    input  logic [7:0] wr_data_i,
    output logic [7:0] rd_data_o,
    output logic       cpu_res_o,
    output logic       cpu_ready_o
);

    // Control byte
    logic [7:0] ctrl_q;

    // CPU comes up held in reset and not ready
    always_ff @(posedge clk16_i) begin
        if (reset_i) begin
            ctrl_q <= pet_pkg::CTRL_RESET_VALUE;
        end else if (wr_en_i) begin
            ctrl_q <= wr_data_i;
        end
    end

    // Upper bits are scratch, read back as written
    assign rd_data_o   = ctrl_q;

    // Pin mapping
    assign cpu_res_o   = ctrl_q[0];
    assign cpu_ready_o = ctrl_q[1];

endmodule

`default_nettype wire

// File: src/bus_timing.sv
`timescale 1ns/1ns
`default_nettype none

module bus_timing (
    input  logic clk16_i,
    input  logic reset_i,
    input  logic req_valid_i,
    output logic slot_en_o,
    output logic done_o,
    output logic cpu_clk_o,
    output logic cpu_be_o
);

    pet_pkg::frame_cnt_t frame_cnt_q;
    pet_pkg::frame_cnt_t frame_cnt_next;

    // Request sampled at cycle 0 owns the FPGA slot of this frame
    logic                owned_q;
    logic                cpu_clk_q;

    assign frame_cnt_next = (frame_cnt_q == pet_pkg::frame_cnt_t'(pet_pkg::FRAME_LEN - 1))
                          ? '0
                          : frame_cnt_q + 1'b1;

    always_ff @(posedge clk16_i) begin
        if (reset_i) begin
            frame_cnt_q <= '0;
            owned_q     <= 1'b0;
            cpu_clk_q   <= 1'b0;
        end else begin
            frame_cnt_q <= frame_cnt_next;
            // Registered from next count so phi2 is glitch free and lands on cycle 8
            cpu_clk_q   <= (frame_cnt_next >= pet_pkg::CPU_PHI2_FIRST);
            if (frame_cnt_q == '0) begin
                owned_q <= req_valid_i;
            end
        end
    end

    // Strobe window inside the FPGA half
    assign slot_en_o = owned_q &&
                       (frame_cnt_q >= pet_pkg::SPI_SLOT_FIRST) &&
                       (frame_cnt_q <= pet_pkg::SPI_SLOT_LAST);

    assign done_o    = owned_q && (frame_cnt_q == pet_pkg::SPI_SLOT_LAST);

    assign cpu_clk_o = cpu_clk_q;

    // 6502 drives the bus in the second half only
    assign cpu_be_o  = (frame_cnt_q >= pet_pkg::CPU_PHI2_FIRST);

    // Done lands on the last FPGA cycle while the request is still held
    a_done_at_slot_end: assert property (
        @(posedge clk16_i) disable iff (reset_i)
        done_o |=> $rose(cpu_be_o) && $past(req_valid_i)
    );

endmodule

`default_nettype wire

// File: src/spi_cmd.sv
`timescale 1ns/1ns
`default_nettype none

module spi_cmd (
    input  logic                           clk16_i,
    input  logic                           reset_i,
    input  logic [7:0]                     rx_byte_i,
    input  logic                           rx_valid_i,
    input  logic                           cs_active_i,
    output logic [7:0]                     tx_byte_o,
    output logic                           req_valid_o,
    output logic [pet_pkg::BUS_ADDR_W-1:0] req_addr_o,
    output logic [7:0]                     req_data_o,
    output logic                           req_rw_n_o,
    input  logic                           req_done_i,
    input  logic [7:0]                     rd_data_i,
    output logic                           spi_ready_o
);

    pet_pkg::cmd_state_e state_q;
    pet_pkg::spi_op_e    op_q;

    // Done delayed by one, read data from bus_ctrl is registered
    logic                done_q;
    logic                op_known;

    assign op_known = (rx_byte_i[7:4] == pet_pkg::OP_WRITE) ||
                      (rx_byte_i[7:4] == pet_pkg::OP_READ);

    // Control path
    always_ff @(posedge clk16_i) begin
        if (reset_i) begin
            state_q     <= pet_pkg::CMD;
            req_valid_o <= 1'b0;
            req_rw_n_o  <= 1'b1;
            done_q      <= 1'b0;
        end else begin
            done_q <= req_done_i;
            // CS release restarts parsing, but never abandons a bus access in flight
            if (!cs_active_i && state_q != pet_pkg::WAIT_BUS) begin
                state_q <= pet_pkg::CMD;
            end else begin
                case (state_q)
                    pet_pkg::CMD: begin
                        // Unknown opcode, ignore rest of the transfer
                        if (rx_valid_i) begin
                            state_q <= op_known ? pet_pkg::ADDR_HI : pet_pkg::REPLY;
                        end
                    end
                    pet_pkg::ADDR_HI: begin
                        if (rx_valid_i) begin
                            state_q <= pet_pkg::ADDR_LO;
                        end
                    end
                    pet_pkg::ADDR_LO: begin
                        if (rx_valid_i) begin
                            if (op_q == pet_pkg::OP_READ) begin
                                // Read goes out now, reply byte comes later
                                req_valid_o <= 1'b1;
                                req_rw_n_o  <= 1'b1;
                                state_q     <= pet_pkg::WAIT_BUS;
                            end else begin
                                state_q <= pet_pkg::DATA;
                            end
                        end
                    end
                    pet_pkg::DATA: begin
                        if (rx_valid_i) begin
                            req_valid_o <= 1'b1;
                            req_rw_n_o  <= 1'b0;
                            state_q     <= pet_pkg::WAIT_BUS;
                        end
                    end
                    pet_pkg::WAIT_BUS: begin
                        if (req_done_i) begin
                            req_valid_o <= 1'b0;
                            state_q     <= pet_pkg::REPLY;
                        end
                    end
                    // Sit here until CS goes high
                    pet_pkg::REPLY: ;
                    default: state_q <= pet_pkg::CMD;
                endcase
            end
        end
    end

    // Command fields, held while the request is pending
    always_ff @(posedge clk16_i) begin
        if (rx_valid_i) begin
            case (state_q)
                pet_pkg::CMD: begin
                    op_q                               <= pet_pkg::spi_op_e'(rx_byte_i[7:4]);
                    req_addr_o[pet_pkg::BUS_ADDR_W-1] <= rx_byte_i[0];
                end
                pet_pkg::ADDR_HI: req_addr_o[15:8] <= rx_byte_i;
                pet_pkg::ADDR_LO: req_addr_o[7:0]  <= rx_byte_i;
                pet_pkg::DATA:    req_data_o       <= rx_byte_i;
                default: ;
            endcase
        end
        // Reply byte for the host
        if (done_q && req_rw_n_o) begin
            tx_byte_o <= rd_data_i;
        end
    end

    // Low from request until the cycle after done
    assign spi_ready_o = (state_q != pet_pkg::WAIT_BUS) && !done_q;

    // Host clocked a byte while the bus access was still pending
    a_no_rx_while_busy: assert property (
        @(posedge clk16_i) disable iff (reset_i)
        !(rx_valid_i && state_q == pet_pkg::WAIT_BUS)
    );

endmodule

`default_nettype wire

// File: src/spi_target.sv
`timescale 1ns/1ns
`default_nettype none

module spi_target (
    input  logic       clk16_i,
    input  logic       reset_i,
    input  logic       spi_sck_i,
    input  logic       spi_cs_ni,
    input  logic       spi_rx_i,
    output logic       spi_tx_o,
    input  logic [7:0] tx_byte_i,
    output logic [7:0] rx_byte_o,
    output logic       rx_valid_o,
    output logic       cs_active_o
);

    // Two-flop synchronizers into the clk16 domain
    logic [1:0] sck_sync_q;
    logic [1:0] cs_n_sync_q;
    logic [1:0] mosi_sync_q;

    // Previous synced SCK for edge detection
    logic       sck_prev_q;

    logic       sck_rise;
    logic       sck_fall;
    logic       cs_active;

    logic [2:0] bit_cnt_q;
    logic [7:0] rx_shift_q;
    logic [7:0] tx_shift_q;

    always_ff @(posedge clk16_i) begin
        if (reset_i) begin
            sck_sync_q  <= 2'b00;
            cs_n_sync_q <= 2'b11;
            mosi_sync_q <= 2'b00;
            sck_prev_q  <= 1'b0;
        end else begin
            sck_sync_q  <= {sck_sync_q[0], spi_sck_i};
            cs_n_sync_q <= {cs_n_sync_q[0], spi_cs_ni};
            mosi_sync_q <= {mosi_sync_q[0], spi_rx_i};
            sck_prev_q  <= sck_sync_q[1];
        end
    end

    // MOSI passes the same number of flops as SCK, so it lines up with the edge
    assign sck_rise  = sck_sync_q[1] & ~sck_prev_q;
    assign sck_fall  = ~sck_sync_q[1] & sck_prev_q;
    assign cs_active = ~cs_n_sync_q[1];

    // Bit counter, cleared while CS is high
    always_ff @(posedge clk16_i) begin
        if (reset_i) begin
            bit_cnt_q  <= 3'd0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (!cs_active) begin
                bit_cnt_q <= 3'd0;
            end else if (sck_rise) begin
                bit_cnt_q  <= bit_cnt_q + 3'd1;
                // Eighth rising edge completes the byte
                rx_valid_o <= (bit_cnt_q == 3'd7);
            end
        end
    end

    // Mode 0 shifters, MSB first
    always_ff @(posedge clk16_i) begin
        if (sck_rise) begin
            rx_shift_q <= {rx_shift_q[6:0], mosi_sync_q[1]};
        end
        // Between bytes MISO follows tx_byte_i, so late read data still makes it out
        if (!cs_active || bit_cnt_q == 3'd0) begin
            tx_shift_q <= tx_byte_i;
        end else if (sck_fall) begin
            tx_shift_q <= {tx_shift_q[6:0], 1'b0};
        end
    end

    assign rx_byte_o   = rx_shift_q;
    assign spi_tx_o    = tx_shift_q[7];
    assign cs_active_o = cs_active;

endmodule

`default_nettype wire

// File: src/pet_pkg.sv
`default_nettype none

package pet_pkg;

    // Upper nibble of the first SPI byte
    typedef enum logic [3:0] {
        OP_WRITE = 4'h1,
        OP_READ  = 4'h2
    } spi_op_e;

    // Command parser states
    typedef enum logic [2:0] {
        CMD,
        ADDR_HI,
        ADDR_LO,
        DATA,
        WAIT_BUS,
        REPLY
    } cmd_state_e;

    // System bus width, bit 16 selects the register bank
    localparam int BUS_ADDR_W = 17;

    // Bus frame in clk16 cycles
    localparam int FRAME_LEN   = 16;
    localparam int FRAME_CNT_W = $clog2(FRAME_LEN);

    typedef logic [FRAME_CNT_W-1:0] frame_cnt_t;

    // FPGA strobes only in the back half of the SPI slot
    localparam frame_cnt_t SPI_SLOT_FIRST = 4'd4;
    localparam frame_cnt_t SPI_SLOT_LAST  = 4'd7;

    // 6502 phase 2 starts here
    localparam frame_cnt_t CPU_PHI2_FIRST = 4'd8;

    // Bit 0 CPU reset, bit 1 CPU ready
    localparam logic [7:0] CTRL_RESET_VALUE = 8'h01;

endpackage

`default_nettype wire
